// File: ray_hit_top.f
+incdir+rtl
rtl/ray_hit_pkg.sv
rtl/fifo_array.sv
rtl/tri_regs.sv
rtl/t_divide.sv
rtl/hit_point.sv
rtl/ray_hit_top.sv
test/tb_clock.sv
test/tb_ray_hit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f ray_hit_top.f --top-module tb_ray_hit \
    -o tb_ray_hit \
    && ./obj_dir/tb_ray_hit | tee /dev/stderr | grep -q "^TEST PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: test/tb_ray_hit.sv
`timescale 1ns/10ps
`default_nettype none
`include "ray_hit_config.svh"

module tb_ray_hit;

import ray_hit_pkg::*;

localparam int n_random        = 50;
localparam int n_parallel      = 2;
localparam int n_burst         = 24;             // More than the rays the pipeline can hold
localparam int held_rays       = `RH_RAY_DEPTH + `RH_HIT_DEPTH + 3;  // Divider and hit_point
localparam int total_rays      = n_random + n_parallel + n_burst;
localparam int watchdog_cycles = total_rays * (`RH_DIV_BITS + 20) + 2000;
localparam logic [1:0] resp_okay   = 2'b00;
localparam logic [1:0] resp_slverr = 2'b10;

logic                     clock;
logic                     arst_n;
logic [`RH_ADDR_BITS-1:0] awaddr;
logic                     awvalid;
logic                     awready;
logic [31:0]              wdata;
logic [3:0]               wstrb;
logic                     wvalid;
logic                     wready;
logic [1:0]               bresp;
logic                     bvalid;
logic                     bready;
logic [`RH_ADDR_BITS-1:0] araddr;
logic                     arvalid;
logic                     arready;
logic [31:0]              rdata;
logic [1:0]               rresp;
logic                     rvalid;
logic                     rready;
logic                     ray_wr_en;
ray_t                     ray_din;
logic                     ray_full;
logic                     hit_rd_en;
hit_t                     hit_dout;
logic                     hit_empty;

logic [`RH_ADDR_BITS-1:0] tri_addr [6] = '{`RH_REG_NORMAL_X, `RH_REG_NORMAL_Y,
    `RH_REG_NORMAL_Z, `RH_REG_V0_X, `RH_REG_V0_Y, `RH_REG_V0_Z};
logic [31:0] tri_val [6] = '{32'h0001_0000, 32'h0002_0000, 32'hFFFF_8000,
                             32'h0000_4000, 32'hFFFF_0000, 32'h0003_0000};
vec3_t       exp_normal;
vec3_t       exp_v0;
hit_t        exp_q [$];
string       name_q [$];
string       cur_test;
logic [31:0] lfsr = 32'h20c2;
logic        drain_on = 1'b0;
logic        saw_full;
int          errors = 0;
int          checks = 0;
int          tests_run = 0;
int          errors_at_start;
int          rays_sent = 0;
int          parallels_sent = 0;

tb_clock clk_gen (.clock(clock), .arst_n(arst_n));

ray_hit_top dut (.*);

// ****************************************
// Reference model and random stimulus
// ****************************************
function automatic coord_t q_mul(input coord_t a, input coord_t b);
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    wa = a;
    wb = b;
    return coord_t'((wa * wb) >>> `RH_Q_BITS);
endfunction

function automatic coord_t dot3(input vec3_t a, input vec3_t b);
    return q_mul(a.x, b.x) + q_mul(a.y, b.y) + q_mul(a.z, b.z);
endfunction

function automatic hit_t ray_hit_ref(input ray_t r, input vec3_t n, input vec3_t p0);
    vec3_t              rel;
    coord_t             num;
    coord_t             den;
    coord_t             t;
    logic signed [63:0] wide_num;
    logic signed [63:0] wide_den;
    hit_t               h;
    rel.x = p0.x - r.origin.x;
    rel.y = p0.y - r.origin.y;
    rel.z = p0.z - r.origin.z;
    num = dot3(n, rel);
    den = dot3(n, r.dir);
    h.parallel = (den == 0);
    t = '0;                                       // Parallel rays stay at the origin
    if (den != 0) begin
        wide_num = num;
        wide_den = den;
        t = coord_t'((wide_num <<< `RH_Q_BITS) / wide_den);
    end
    h.point.x = r.origin.x + q_mul(r.dir.x, t);
    h.point.y = r.origin.y + q_mul(r.dir.y, t);
    h.point.z = r.origin.z + q_mul(r.dir.z, t);
    return h;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
endfunction

function automatic coord_t random_coord();
    logic [31:0] bits;
    bits = rand_bits(20);
    return coord_t'({{12{bits[19]}}, bits[19:0]});  // Within plus or minus 8.0
endfunction

function automatic ray_t make_ray();
    ray_t r;
    r.origin = '{x: random_coord(), y: random_coord(), z: random_coord()};
    do begin
        r.dir = '{x: random_coord(), y: random_coord(), z: random_coord()};
    end while (dot3(exp_normal, r.dir) == 0);
    return r;
endfunction

// ****************************************
// Bus and stream tasks
// ****************************************
task automatic check(input string name, input logic [127:0] expected,
                     input logic [127:0] actual);
    checks++;
    if (expected !== actual) begin
        $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        errors++;
    end
endtask

task automatic reg_write(input logic [`RH_ADDR_BITS-1:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output logic [1:0] resp);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    bready  = 1'b1;
    #1;
    check({cur_test, " awready and wready"}, 2'b11, {awready, wready});
    @(negedge clock);
    while (!bvalid) @(negedge clock);             // bvalid follows the accepting edge
    awvalid = 1'b0;
    wvalid  = 1'b0;
    resp    = bresp;
    @(negedge clock);
    bready  = 1'b0;
endtask

task automatic reg_read(input logic [`RH_ADDR_BITS-1:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    #1;
    check({cur_test, " arready"}, 1'b1, arready);
    @(negedge clock);
    while (!rvalid) @(negedge clock);
    arvalid = 1'b0;
    data    = rdata;
    resp    = rresp;
    @(negedge clock);
    rready  = 1'b0;
endtask

task automatic send_ray(input ray_t r);
    hit_t expected_hit;
    while (ray_full) @(negedge clock);
    expected_hit = ray_hit_ref(r, exp_normal, exp_v0);
    exp_q.push_back(expected_hit);
    name_q.push_back($sformatf("%s ray %0d", cur_test, rays_sent));
    rays_sent++;
    if (expected_hit.parallel) begin
        parallels_sent++;
    end
    ray_din   = r;
    ray_wr_en = 1'b1;
    @(negedge clock);
    ray_wr_en = 1'b0;
endtask

task automatic set_drain(input logic on);
    @(posedge clock);
    drain_on = on;                                // Read by the comparison process on negedges
    @(negedge clock);
endtask

task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clock);
    @(negedge clock);
endtask

task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
endtask

task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
        $display("%s: passed", cur_test);
    end else begin
        $display("%s: failed with %0d errors", cur_test, errors - errors_at_start);
    end
endtask

// ****************************************
// Hit comparison and watchdog
// ****************************************
initial begin
    hit_rd_en = 1'b0;
    forever begin
        @(negedge clock);
        hit_rd_en = 1'b0;
        if (arst_n && drain_on && !hit_empty) begin
            if (exp_q.size() == 0) begin
                $display("A hit came out with no ray outstanding, point %0h", hit_dout);
                errors++;
            end else begin
                check(name_q.pop_front(), exp_q.pop_front(), hit_dout);
            end
            hit_rd_en = 1'b1;                     // Pops the head at the next edge
        end
    end
end

initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             watchdog_cycles);
    $display("TEST FAIL");
    $finish;
end

// ****************************************
// Test sequence
// ****************************************
initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    ray_t        r;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    ray_wr_en = 1'b0;
    ray_din   = '0;
    exp_normal = '{x: tri_val[0], y: tri_val[1], z: tri_val[2]};
    exp_v0     = '{x: tri_val[3], y: tri_val[4], z: tri_val[5]};
    @(posedge arst_n);
    @(negedge clock);

    start_test("reg_readback");
    for (int i = 0; i < 6; i++) begin
        reg_write(tri_addr[i], tri_val[i], 4'hF, resp);
        check("reg_readback write response", resp_okay, resp);
    end
    reg_write(`RH_REG_CTRL, 32'h1, 4'hF, resp);
    for (int i = 0; i < 6; i++) begin
        reg_read(tri_addr[i], data, resp);
        check($sformatf("reg_readback reg %0h", tri_addr[i]), tri_val[i], data);
    end
    reg_write(`RH_REG_V0_Z, 32'hA5A5_A5A5, 4'b0110, resp);
    reg_read(`RH_REG_V0_Z, data, resp);
    check("reg_readback wstrb", {tri_val[5][31:24], 16'hA5A5, tri_val[5][7:0]}, data);
    reg_write(`RH_REG_V0_Z, tri_val[5], 4'hF, resp);
    reg_write(`RH_REG_CTRL, 32'h0, 4'b1110, resp);  // Byte 0 untouched so enable stays set
    reg_read(`RH_REG_CTRL, data, resp);
    check("reg_readback control", 32'h1, data);
    end_test();

    start_test("random_rays");
    set_drain(1'b1);
    for (int i = 0; i < n_random; i++) begin
        send_ray(make_ray());
    end
    wait_drained();
    end_test();

    start_test("parallel_ray");
    r = make_ray();
    r.dir = '{x: 32'h0002_0000, y: 32'hFFFF_0000, z: 32'h0};
    send_ray(r);
    r = make_ray();
    r.dir = '{x: 32'h0001_0000, y: 32'h0, z: 32'h0002_0000};
    send_ray(r);
    wait_drained();
    end_test();

    start_test("back_pressure");
    set_drain(1'b0);
    saw_full = 1'b0;
    for (int i = 0; i < n_burst; i++) begin
        if (ray_full && !drain_on) begin
            repeat (`RH_DIV_BITS + 20) @(negedge clock);  // Longer than one ray needs
            if (ray_full) begin
                saw_full = 1'b1;
                check("back_pressure rays held", held_rays, i);
                set_drain(1'b1);
            end
        end
        send_ray(make_ray());
    end
    if (!saw_full) begin
        $display("back_pressure: ray_full never stayed high while hits were held back");
        errors++;
    end
    set_drain(1'b1);
    wait_drained();
    check("back_pressure hit fifo empty", 1'b1, hit_empty);
    end_test();

    start_test("counters");
    reg_read(`RH_REG_RAY_CNT, data, resp);
    check("counters ray count", rays_sent, data);
    reg_read(`RH_REG_PAR_CNT, data, resp);
    check("counters parallel count", parallels_sent, data);
    end_test();

    start_test("errors");
    reg_write(`RH_REG_RAY_CNT, 32'hDEAD_0000, 4'hF, resp);
    check("errors counter write response", resp_slverr, resp);
    reg_write(6'h3C, 32'hFFFF_FFFF, 4'hF, resp);
    check("errors unmapped write response", resp_slverr, resp);
    reg_read(`RH_REG_RAY_CNT, data, resp);
    check("errors ray count kept", rays_sent, data);
    for (int i = 0; i < 6; i++) begin
        reg_read(tri_addr[i], data, resp);
        check($sformatf("errors reg %0h kept", tri_addr[i]), tri_val[i], data);
    end
    reg_read(6'h3C, data, resp);
    check("errors unmapped read data", 32'h0, data);
    check("errors unmapped read response", resp_slverr, resp);
    end_test();

    $display("Finished %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 5
) (
    output logic clock,
    output logic arst_n
);

initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
end

initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;                                // Released away from the active edge
end

endmodule

`default_nettype wire

// File: rtl/ray_hit_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "ray_hit_config.svh"

module ray_hit_top (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic [`RH_ADDR_BITS-1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`RH_ADDR_BITS-1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic                      ray_wr_en,
    input  ray_hit_pkg::ray_t         ray_din,
    output logic                      ray_full,
    input  logic                      hit_rd_en,
    output ray_hit_pkg::hit_t         hit_dout,
    output logic                      hit_empty
);

import ray_hit_pkg::*;

vec3_t  normal;
vec3_t  v0;
logic   enable;
logic   ray_done;
logic   parallel_seen;
logic   ray_rd_en;
ray_t   ray_dout;
logic   ray_empty;
logic   div_valid;
logic   div_ready;
ray_t   div_ray;
coord_t div_t;
logic   div_parallel;
logic   hit_wr_en;
hit_t   hit_din;
logic   hit_full;

tri_regs u_tri_regs (
    .clock          (clock),
    .arst_n         (arst_n),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wstrb          (wstrb),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .normal         (normal),
    .v0             (v0),
    .enable         (enable),
    .ray_done       (ray_done),
    .parallel_seen  (parallel_seen)
);

fifo_array #(
    .payload_t      (ray_t),
    .depth          (`RH_RAY_DEPTH)
) ray_fifo (
    .clock          (clock),
    .arst_n         (arst_n),
    .wr_en          (ray_wr_en),
    .din            (ray_din),
    .full           (ray_full),
    .rd_en          (ray_rd_en),
    .dout           (ray_dout),
    .empty          (ray_empty)
);

t_divide u_t_divide (
    .clock          (clock),
    .arst_n         (arst_n),
    .normal         (normal),
    .v0             (v0),
    .enable         (enable),
    .ray_rd_en      (ray_rd_en),
    .ray_dout       (ray_dout),
    .ray_empty      (ray_empty),
    .out_valid      (div_valid),
    .out_ready      (div_ready),
    .out_ray        (div_ray),
    .out_t          (div_t),
    .out_parallel   (div_parallel),
    .ray_done       (ray_done),
    .parallel_seen  (parallel_seen)
);

hit_point u_hit_point (
    .clock          (clock),
    .arst_n         (arst_n),
    .in_valid       (div_valid),
    .in_ready       (div_ready),
    .in_ray         (div_ray),
    .in_t           (div_t),
    .in_parallel    (div_parallel),
    .hit_wr_en      (hit_wr_en),
    .hit_din        (hit_din),
    .hit_full       (hit_full)
);

fifo_array #(
    .payload_t      (hit_t),
    .depth          (`RH_HIT_DEPTH)
) hit_fifo (
    .clock          (clock),
    .arst_n         (arst_n),
    .wr_en          (hit_wr_en),
    .din            (hit_din),
    .full           (hit_full),
    .rd_en          (hit_rd_en),
    .dout           (hit_dout),
    .empty          (hit_empty)
);

endmodule

`default_nettype wire

// File: rtl/hit_point.sv
`timescale 1ns/10ps
`default_nettype none

module hit_point (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  ray_hit_pkg::ray_t   in_ray,
    input  ray_hit_pkg::coord_t in_t,
    input  logic                in_parallel,
    output logic                hit_wr_en,
    output ray_hit_pkg::hit_t   hit_din,
    input  logic                hit_full
);

import ray_hit_pkg::*;

logic  s1_valid;
logic  s1_parallel;
vec3_t s1_origin;
vec3_t s1_scaled;                             // Direction times t
logic  s2_valid;
hit_t  s2_hit;
logic  adv1;
logic  adv2;

always_comb begin
    adv2 = !s2_valid || !hit_full;            // Last stage empty or able to write
    adv1 = !s1_valid || adv2;
end

assign in_ready  = adv1;
assign hit_wr_en = s2_valid && !hit_full;
assign hit_din   = s2_hit;

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        s1_valid <= 1'b0;
        s2_valid <= 1'b0;
    end else begin
        if (adv1) begin
            s1_valid <= in_valid;
        end
        if (adv2) begin
            s2_valid <= s1_valid;
        end
    end
end

always_ff @(posedge clock) begin
    if (adv1 && in_valid) begin
        s1_origin   <= in_ray.origin;
        s1_scaled.x <= fx_mul(in_ray.dir.x, in_t);
        s1_scaled.y <= fx_mul(in_ray.dir.y, in_t);
        s1_scaled.z <= fx_mul(in_ray.dir.z, in_t);
        s1_parallel <= in_parallel;           // t is 0 here, so the point is the origin
    end
    if (adv2 && s1_valid) begin
        s2_hit.point.x  <= s1_origin.x + s1_scaled.x;
        s2_hit.point.y  <= s1_origin.y + s1_scaled.y;
        s2_hit.point.z  <= s1_origin.z + s1_scaled.z;
        s2_hit.parallel <= s1_parallel;
    end
end

endmodule

`default_nettype wire

// File: rtl/t_divide.sv
`timescale 1ns/10ps
`default_nettype none
`include "ray_hit_config.svh"

module t_divide (
    input  logic                clock,
    input  logic                arst_n,
    input  ray_hit_pkg::vec3_t  normal,
    input  ray_hit_pkg::vec3_t  v0,
    input  logic                enable,
    output logic                ray_rd_en,
    input  ray_hit_pkg::ray_t   ray_dout,
    input  logic                ray_empty,
    output logic                out_valid,
    input  logic                out_ready,
    output ray_hit_pkg::ray_t   out_ray,
    output ray_hit_pkg::coord_t out_t,
    output logic                out_parallel,
    output logic                ray_done,
    output logic                parallel_seen
);

import ray_hit_pkg::*;

localparam int cnt_bits = $clog2(`RH_DIV_BITS);

typedef enum logic [2:0] {st_idle, st_dot1, st_dot2, st_div, st_out} state_t;

state_t                  state;
ray_t                    ray_q;
coord_t                  num_p [3];
coord_t                  den_p [3];
coord_t                  num;
coord_t                  den;
logic                    neg_q;
logic                    par_q;
logic [cnt_bits-1:0]     cnt;
logic [`RH_DIV_BITS-1:0] dvd;                 // Dividend, quotient shifts in from the right
logic [31:0]             dsr;
logic [31:0]             rem;
logic [32:0]             rem_shift;
logic [32:0]             rem_sub;

function automatic logic [31:0] abs32(input coord_t v);
    return v[31] ? 32'(-v) : 32'(v);
endfunction

always_comb begin
    num       = num_p[0] + num_p[1] + num_p[2];
    den       = den_p[0] + den_p[1] + den_p[2];
    rem_shift = {rem, dvd[`RH_DIV_BITS-1]};
    rem_sub   = rem_shift - {1'b0, dsr};      // Bit 32 set means the divisor did not fit
end

assign ray_rd_en     = (state == st_idle) && enable && !ray_empty;
assign out_valid     = (state == st_out);
assign out_ray       = ray_q;
assign out_parallel  = par_q;
assign out_t         = neg_q ? coord_t'(-dvd[31:0]) : coord_t'(dvd[31:0]);
assign ray_done      = out_valid && out_ready;
assign parallel_seen = ray_done && par_q;

// ****************************************
// Control FSM
// ****************************************
always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        state <= st_idle;
    end else begin
        case (state)
            st_idle: if (ray_rd_en) state <= st_dot1;
            st_dot1: state <= st_dot2;
            st_dot2: state <= (den == '0) ? st_out : st_div;  // Parallel skips the divide
            st_div:  if (cnt == cnt_bits'(`RH_DIV_BITS - 1)) state <= st_out;
            st_out:  if (out_ready) state <= st_idle;
            default: state <= st_idle;
        endcase
    end
end

// ****************************************
// Dot products and restoring divide
// ****************************************
always_ff @(posedge clock) begin
    if (ray_rd_en) begin
        ray_q <= ray_dout;
    end
    if (state == st_dot1) begin
        num_p[0] <= fx_mul(normal.x, v0.x - ray_q.origin.x);
        num_p[1] <= fx_mul(normal.y, v0.y - ray_q.origin.y);
        num_p[2] <= fx_mul(normal.z, v0.z - ray_q.origin.z);
        den_p[0] <= fx_mul(normal.x, ray_q.dir.x);
        den_p[1] <= fx_mul(normal.y, ray_q.dir.y);
        den_p[2] <= fx_mul(normal.z, ray_q.dir.z);
    end
    if (state == st_dot2) begin
        par_q <= (den == '0);
        neg_q <= num[31] ^ den[31];
        dsr   <= abs32(den);
        rem   <= '0;
        cnt   <= '0;
        dvd   <= (den == '0) ? '0 : {abs32(num), {`RH_Q_BITS{1'b0}}};
    end
    if (state == st_div) begin
        cnt <= cnt + 1'b1;
        dvd <= {dvd[`RH_DIV_BITS-2:0], ~rem_sub[32]};
        rem <= rem_sub[32] ? rem_shift[31:0] : rem_sub[31:0];
    end
end

// The result waits for hit_point without changing
assert property (@(posedge clock) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_t))
    else $error("t_divide: out_t changed while stalled");

endmodule

`default_nettype wire

// File: rtl/tri_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "ray_hit_config.svh"

module tri_regs (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic [`RH_ADDR_BITS-1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`RH_ADDR_BITS-1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output ray_hit_pkg::vec3_t        normal,
    output ray_hit_pkg::vec3_t        v0,
    output logic                      enable,
    input  logic                      ray_done,
    input  logic                      parallel_seen
);

import ray_hit_pkg::*;

localparam logic [1:0] resp_okay   = 2'b00;
localparam logic [1:0] resp_slverr = 2'b10;

coord_t      tri_q [6];                       // Normal x y z, then v0 x y z
logic [31:0] ray_cnt;
logic [31:0] par_cnt;
logic        wr_fire;

function automatic coord_t apply_strb(input coord_t old_val, input logic [31:0] data,
                                      input logic [3:0] strb);
    coord_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            res[8*b +: 8] = data[8*b +: 8];
        end
    end
    return res;
endfunction

assign normal  = '{x: tri_q[0], y: tri_q[1], z: tri_q[2]};
assign v0      = '{x: tri_q[3], y: tri_q[4], z: tri_q[5]};
assign wr_fire = awvalid && wvalid && !bvalid;
assign awready = wr_fire;                     // Address and data accepted together
assign wready  = wr_fire;
assign arready = !rvalid;

// ****************************************
// Write channel
// ****************************************
always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        tri_q  <= '{default: '0};
        enable <= 1'b0;
        bvalid <= 1'b0;
        bresp  <= resp_okay;
    end else begin
        if (bvalid && bready) begin
            bvalid <= 1'b0;
        end
        if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= resp_okay;
            case (awaddr)
                `RH_REG_NORMAL_X: tri_q[0] <= apply_strb(tri_q[0], wdata, wstrb);
                `RH_REG_NORMAL_Y: tri_q[1] <= apply_strb(tri_q[1], wdata, wstrb);
                `RH_REG_NORMAL_Z: tri_q[2] <= apply_strb(tri_q[2], wdata, wstrb);
                `RH_REG_V0_X:     tri_q[3] <= apply_strb(tri_q[3], wdata, wstrb);
                `RH_REG_V0_Y:     tri_q[4] <= apply_strb(tri_q[4], wdata, wstrb);
                `RH_REG_V0_Z:     tri_q[5] <= apply_strb(tri_q[5], wdata, wstrb);
                `RH_REG_CTRL:     enable   <= wstrb[0] ? wdata[0] : enable;
                default:          bresp    <= resp_slverr;  // Counters and holes
            endcase
        end
    end
end

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        ray_cnt <= '0;
        par_cnt <= '0;
    end else begin
        ray_cnt <= ray_cnt + {31'b0, ray_done};    // Wraps at 2**32
        par_cnt <= par_cnt + {31'b0, parallel_seen};
    end
end

// ****************************************
// Read channel
// ****************************************
always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        rvalid <= 1'b0;
        rdata  <= '0;
        rresp  <= resp_okay;
    end else begin
        if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
        if (arvalid && arready) begin
            rvalid <= 1'b1;
            rresp  <= resp_okay;
            case (araddr)
                `RH_REG_NORMAL_X: rdata <= tri_q[0];
                `RH_REG_NORMAL_Y: rdata <= tri_q[1];
                `RH_REG_NORMAL_Z: rdata <= tri_q[2];
                `RH_REG_V0_X:     rdata <= tri_q[3];
                `RH_REG_V0_Y:     rdata <= tri_q[4];
                `RH_REG_V0_Z:     rdata <= tri_q[5];
                `RH_REG_CTRL:     rdata <= {31'b0, enable};
                `RH_REG_RAY_CNT:  rdata <= ray_cnt;
                `RH_REG_PAR_CNT:  rdata <= par_cnt;
                default: begin
                    rdata <= '0;
                    rresp <= resp_slverr;
                end
            endcase
        end
    end
end

assert property (@(posedge clock) disable iff (!arst_n) bvalid && !bready |=> bvalid)
    else $error("tri_regs: bvalid dropped before bready");

endmodule

`default_nettype wire

// File: rtl/fifo_array.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_array #(
    parameter type payload_t = ray_hit_pkg::ray_t,
    parameter int  depth     = 8
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

payload_t            mem [depth];
logic [ptr_bits-1:0] wr_ptr;
logic [ptr_bits-1:0] rd_ptr;
logic [ptr_bits:0]   count;
logic                do_wr;
logic                do_rd;

function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    return (ptr == ptr_bits'(depth - 1)) ? '0 : ptr + 1'b1;
endfunction

always_comb begin
    full  = (count == (ptr_bits + 1)'(depth));
    empty = (count == '0);
    do_wr = wr_en && !full;
    do_rd = rd_en && !empty;
    dout  = mem[rd_ptr];                          // Head entry shows while not empty
end

always_ff @(posedge clock) begin
    if (do_wr) begin
        mem[wr_ptr] <= din;
    end
end

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_wr) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
        if (do_rd) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
        case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

// The producer and consumer both honour the flags
assert property (@(posedge clock) disable iff (!arst_n) !(wr_en && full))
    else $error("fifo_array: write while full");

assert property (@(posedge clock) disable iff (!arst_n) !(rd_en && empty))
    else $error("fifo_array: read while empty");

endmodule

`default_nettype wire

// File: rtl/ray_hit_pkg.sv
`default_nettype none
`include "ray_hit_config.svh"

package ray_hit_pkg;

    typedef logic signed [31:0] coord_t;      // Signed fixed point

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t origin;
        vec3_t dir;
    } ray_t;

    typedef struct packed {
        vec3_t point;
        logic  parallel;                      // Ray runs parallel to the plane
    } hit_t;

    // Fixed point product, the 64 bit result shifted back by the fraction bits
    function automatic coord_t fx_mul(input coord_t a, input coord_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return coord_t'(prod >>> `RH_Q_BITS);
    endfunction

endpackage

`default_nettype wire

// File: rtl/ray_hit_config.svh
`ifndef RAY_HIT_CONFIG_SVH
`define RAY_HIT_CONFIG_SVH

`define RH_Q_BITS        16                   // Fraction bits of every coordinate
`define RH_RAY_DEPTH     8
`define RH_HIT_DEPTH     8
`define RH_DIV_BITS      (32 + `RH_Q_BITS)    // One quotient bit per cycle
`define RH_ADDR_BITS     6

// AXI4-Lite register map, word aligned
`define RH_REG_NORMAL_X  6'h00
`define RH_REG_NORMAL_Y  6'h04
`define RH_REG_NORMAL_Z  6'h08
`define RH_REG_V0_X      6'h0C
`define RH_REG_V0_Y      6'h10
`define RH_REG_V0_Z      6'h14
`define RH_REG_CTRL      6'h18                // Bit 0 is enable
`define RH_REG_RAY_CNT   6'h1C                // Read only
`define RH_REG_PAR_CNT   6'h20                // Read only

`endif
